// ==== host_chan_pkg.sv ====
// ==========================================================
// Host memory read channel types
// ==========================================================
package host_chan_pkg;

    // One cache line of payload moves as a single 64 bit word
    localparam int LINE_BITS = 64;

    // Host addresses count whole cache lines, not bytes
    localparam int LINE_ADDR_BITS = 32;

    // The tag travels with a read and comes back with its response
    // It carries nothing but a scoreboard slot index, which caps the
    // scoreboard at 256 slots
    localparam int TAG_BITS = 8;

    // Payload of one line as it comes back from host memory
    typedef logic [LINE_BITS-1:0] line_t;

    // Line address in host memory
    // The ring base plus a ring index gives the address of a slot
    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    // Request tag, returned unchanged with the response
    typedef logic [TAG_BITS-1:0] tag_t;

endpackage

// ==== ring_buf_pkg.sv ====
// ==========================================================
// Ring buffer geometry
// ==========================================================
package ring_buf_pkg;

    // The ring holds 64 lines
    // Indices wrap from the last slot to the first on their own, so the
    // number of slots has to stay a power of two
    localparam int RING_IDX_BITS = 6;

    // Number of line slots in the ring
    localparam int RING_SIZE = 1 << RING_IDX_BITS;

    // Index of a line slot in the ring
    // The host side and the reader both count in this type, and
    // a difference of two indices is the number of lines between them
    typedef logic [RING_IDX_BITS-1:0] ring_idx_t;

endpackage

// ==== host_chan_if.sv ====
`timescale 1ns/1ps

interface host_chan_if;
    import host_chan_pkg::*;

    // ==========================================================
    // Read request side
    // ==========================================================

    // Request level, held until the grant consumes it
    logic       rd_req;

    // Line address of the requested ring slot
    line_addr_t rd_addr;

    // Scoreboard slot that will receive the response
    tag_t       rd_tag;

    // Grant from the channel arbiter, only ever high together with rd_req
    logic       rd_grant;

    // ==========================================================
    // Read response side
    // ==========================================================

    // One cycle strobe per response with no back-pressure
    // Responses may come back in any order
    logic       rsp_valid;
    tag_t       rsp_tag;
    line_t      rsp_data;

    // The ring reader issues requests and sinks responses
    modport reader (
        output rd_req, rd_addr, rd_tag,
        input  rd_grant, rsp_valid, rsp_tag, rsp_data
    );

    // Host memory side, the mirror of the reader
    modport host (
        input  rd_req, rd_addr, rd_tag,
        output rd_grant, rsp_valid, rsp_tag, rsp_data
    );

endinterface

// ==== out_fifo2.sv ====
`timescale 1ns/1ps

module out_fifo2
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  host_chan_pkg::line_t enq_data,
    input  logic                 enq_en,
    output logic                 not_full,
    output host_chan_pkg::line_t first,
    input  logic                 deq_en,
    output logic                 not_empty
);
    import host_chan_pkg::*;

    // The head entry always holds the oldest line and drives first directly
    // The tail entry only fills when the head is already occupied
    line_t head_data;
    line_t tail_data;
    logic  head_valid;
    logic  tail_valid;

    // Qualified enqueue and dequeue
    logic  enq_ok;
    logic  deq_ok;

    assign enq_ok = enq_en && !tail_valid;
    assign deq_ok = deq_en && head_valid;

    // All outputs come straight from registers
    assign not_full  = !tail_valid;
    assign not_empty = head_valid;
    assign first     = head_data;

    // Payload moves between the entries without reset
    always_ff @(posedge clk)
    begin
        if (deq_ok)
        begin
            // The tail moves up if present, otherwise a new line goes straight to the head
            head_data <= tail_valid ? tail_data : enq_data;
        end
        else if (enq_ok && !head_valid)
        begin
            head_data <= enq_data;
        end

        // The tail only takes a line when the head stays occupied
        if (enq_ok && head_valid && !deq_ok)
        begin
            tail_data <= enq_data;
        end
    end

    // Valid bits follow the same moves
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            head_valid <= 1'b0;
            tail_valid <= 1'b0;
        end
        else
        begin
            head_valid <= deq_ok ? (tail_valid || enq_ok) : (head_valid || enq_ok);
            tail_valid <= deq_ok ? 1'b0 : (tail_valid || (enq_ok && head_valid));
        end
    end

endmodule

// ==== reorder_scoreboard.sv ====
`timescale 1ns/1ps

module reorder_scoreboard
#(
    parameter int N_SLOTS = 8
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    // Slot allocation, one slot per granted request
    input  logic                 alloc_en,
    output logic                 not_full,
    output host_chan_pkg::tag_t  alloc_tag,

    // Out of order fill from the response channel
    input  logic                 fill_en,
    input  host_chan_pkg::tag_t  fill_tag,
    input  host_chan_pkg::line_t fill_data,

    // In order release of finished lines
    input  logic                 deq_en,
    output logic                 not_empty,
    output host_chan_pkg::line_t first
);
    import host_chan_pkg::*;

    localparam int SLOT_BITS = $clog2(N_SLOTS);

    // Index of one scoreboard slot
    typedef logic [SLOT_BITS-1:0] slot_idx_t;

    // Occupancy needs one more bit so that a full scoreboard can be told
    // apart from an empty one
    typedef logic [SLOT_BITS:0] count_t;

    // ==========================================================
    // Storage
    // ==========================================================

    // Line data, written whenever a response arrives
    line_t              data_mem [N_SLOTS];

    // One bit per slot, set when its response has arrived
    logic [N_SLOTS-1:0] filled;

    // Next slot to hand out and oldest slot still allocated
    slot_idx_t          alloc_ptr;
    slot_idx_t          head_ptr;

    // Number of allocated slots
    count_t             count;

    // Only the low bits of the tag select a slot
    slot_idx_t          fill_slot;

    assign fill_slot = slot_idx_t'(fill_tag);

    // ==========================================================
    // Status and outputs
    // ==========================================================

    assign not_full  = (count != count_t'(N_SLOTS));
    assign alloc_tag = tag_t'(alloc_ptr);

    // The head is released only once it is allocated and its data is in
    // Since filled is a register, the head shows up one cycle after the fill
    assign not_empty = (count != '0) && filled[head_ptr];
    assign first     = data_mem[head_ptr];

    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            data_mem[fill_slot] <= fill_data;
        end
    end

    // Pointers, count and filled bits
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            alloc_ptr <= '0;
            head_ptr  <= '0;
            count     <= '0;
            filled    <= '0;
        end
        else
        begin
            // Pointers wrap on their own since N_SLOTS is a power of two
            if (alloc_en)
            begin
                alloc_ptr <= alloc_ptr + 1'b1;
            end

            if (deq_en)
            begin
                head_ptr <= head_ptr + 1'b1;
                filled[head_ptr] <= 1'b0;
            end

            // A fill never targets the head being released, because a slot gets one response
            if (fill_en)
            begin
                filled[fill_slot] <= 1'b1;
            end

            case ({alloc_en, deq_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== ring_reader.sv ====
`timescale 1ns/1ps

module ring_reader
#(
    parameter int N_SLOTS = 8
)
(
    input  logic                      clk,
    input  logic                      reset_n,

    host_chan_if.reader               chan,

    // Ring geometry and producer position from the host
    input  host_chan_pkg::line_addr_t base_addr,
    input  ring_buf_pkg::ring_idx_t   newest_idx,
    output ring_buf_pkg::ring_idx_t   oldest_idx,

    // Line stream toward the client
    output host_chan_pkg::line_t      rx_data,
    output logic                      rx_rdy,
    input  logic                      rx_enable
);
    import host_chan_pkg::*;
    import ring_buf_pkg::*;

    // Index of the next ring slot to request
    ring_idx_t next_req_idx;

    // Request level and its consumption by a grant
    logic      req_lvl;
    logic      req_fire;

    // Scoreboard handshake
    logic      sb_not_full;
    tag_t      sb_alloc_tag;
    logic      sb_not_empty;
    line_t     sb_first;

    // Output FIFO handshake
    logic      fifo_not_full;
    logic      fifo_enq_en;

    // ==========================================================
    // Read request generation
    // ==========================================================

    // Ask for a line while the host has written past our pointer
    // and a scoreboard slot is free to receive it
    assign req_lvl  = (next_req_idx != newest_idx) && sb_not_full;
    assign req_fire = req_lvl && chan.rd_grant;

    assign chan.rd_req  = req_lvl;

    // Adding the index to the base keeps the ring free of any alignment need
    assign chan.rd_addr = base_addr + line_addr_t'(next_req_idx);
    assign chan.rd_tag  = sb_alloc_tag;

    // A granted request moves on to the next slot
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            next_req_idx <= '0;
        end
        else if (req_fire)
        begin
            next_req_idx <= next_req_idx + 1'b1;
        end
    end

    // ==========================================================
    // Reordering and output buffering
    // ==========================================================

    // Responses land in their tagged slot and leave in request order
    reorder_scoreboard #(
        .N_SLOTS   (N_SLOTS)
    ) scoreboard (
        .clk       (clk),
        .reset_n   (reset_n),
        .alloc_en  (req_fire),
        .not_full  (sb_not_full),
        .alloc_tag (sb_alloc_tag),
        .fill_en   (chan.rsp_valid),
        .fill_tag  (chan.rsp_tag),
        .fill_data (chan.rsp_data),
        .deq_en    (fifo_enq_en),
        .not_empty (sb_not_empty),
        .first     (sb_first)
    );

    // Move the head line whenever the FIFO has room
    assign fifo_enq_en = sb_not_empty && fifo_not_full;

    // The registered FIFO keeps the client path away from the scoreboard
    out_fifo2 out_q (
        .clk       (clk),
        .reset_n   (reset_n),
        .enq_data  (sb_first),
        .enq_en    (fifo_enq_en),
        .not_full  (fifo_not_full),
        .first     (rx_data),
        .deq_en    (rx_enable),
        .not_empty (rx_rdy)
    );

    // The oldest pointer counts lines as they leave the scoreboard
    // Once a line is in the FIFO, its ring slot may be overwritten
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            oldest_idx <= '0;
        end
        else if (fifo_enq_en)
        begin
            oldest_idx <= oldest_idx + 1'b1;
        end
    end

endmodule

// ==== ring_reader_top.sv ====
`timescale 1ns/1ps

module ring_reader_top
#(
    parameter int N_SLOTS = 8
)
(
    input  logic                      clk,
    input  logic                      reset_n,

    // Ring buffer position
    input  host_chan_pkg::line_addr_t base_addr,
    input  ring_buf_pkg::ring_idx_t   newest_idx,
    output ring_buf_pkg::ring_idx_t   oldest_idx,

    // Host read channel, request side
    output logic                      rd_req,
    output host_chan_pkg::line_addr_t rd_addr,
    output host_chan_pkg::tag_t       rd_tag,
    input  logic                      rd_grant,

    // Host read channel, response side
    input  logic                      rsp_valid,
    input  host_chan_pkg::tag_t       rsp_tag,
    input  host_chan_pkg::line_t      rsp_data,

    // Client stream
    output host_chan_pkg::line_t      rx_data,
    output logic                      rx_rdy,
    input  logic                      rx_enable
);

    // ==========================================================
    // Channel bundle
    // ==========================================================

    // The top plays the host end of the channel and maps it to plain ports
    host_chan_if chan ();

    assign rd_req         = chan.rd_req;
    assign rd_addr        = chan.rd_addr;
    assign rd_tag         = chan.rd_tag;
    assign chan.rd_grant  = rd_grant;
    assign chan.rsp_valid = rsp_valid;
    assign chan.rsp_tag   = rsp_tag;
    assign chan.rsp_data  = rsp_data;

    // Ring reader with its scoreboard and output FIFO
    ring_reader #(
        .N_SLOTS    (N_SLOTS)
    ) reader (
        .clk        (clk),
        .reset_n    (reset_n),
        .chan       (chan.reader),
        .base_addr  (base_addr),
        .newest_idx (newest_idx),
        .oldest_idx (oldest_idx),
        .rx_data    (rx_data),
        .rx_rdy     (rx_rdy),
        .rx_enable  (rx_enable)
    );

endmodule

// ==== tb_ring_reader.sv ====
`timescale 1ns/1ps

module tb_ring_reader;
    import host_chan_pkg::*;
    import ring_buf_pkg::*;

    localparam int N_SLOTS     = 8;
    localparam int TOTAL_LINES = 600;
    localparam int BP_CYCLES   = 300;

    // Each line may take up to 40 cycles of 20 ns before the run counts as hung
    localparam int WATCHDOG_NS = TOTAL_LINES * 40 * 20;

    logic       clk = 1'b0;
    logic       reset_n;
    line_addr_t base_addr;
    ring_idx_t  newest_idx;
    ring_idx_t  oldest_idx;
    logic       rd_req;
    line_addr_t rd_addr;
    tag_t       rd_tag;
    logic       rd_grant;
    logic       rsp_valid;
    tag_t       rsp_tag;
    line_t      rsp_data;
    line_t      rx_data;
    logic       rx_rdy;
    logic       rx_enable;

    integer     seed = 32'h8624_2ad0;
    integer     base_rnd;
    int         errors = 0;
    int         cyc = 0;
    int         wr_cnt = 0;
    int         req_cnt = 0;
    int         pop_cnt = 0;
    int         bp_left = 0;
    bit         bp_done = 1'b0;
    bit         done = 1'b0;
    int         k;
    ring_idx_t  ahead;

    // Host memory by line address, and the reads still waiting for a response
    line_t      host_mem [line_addr_t];
    line_addr_t pend_addr [$];
    tag_t       pend_tag [$];

    ring_reader_top #(.N_SLOTS(N_SLOTS)) DUT (.*);

    always #10 clk = ~clk;

    // Line n of the run carries a fixed marker above its own number
    function automatic line_t expected_line(input int n);
        return {32'hC0DE_0000, n[31:0]};
    endfunction

    // ============================================================
    // Compare tasks
    // ============================================================

    task automatic check_line(input string name, input line_t got, input line_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input line_addr_t got, input line_addr_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_idx(input string name, input ring_idx_t got, input ring_idx_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Failures that are not a single wrong value
    task automatic report(input string what);
        errors++;
        $display("Failure at %0t: %s", $time, what);
    endtask

    // Base address keeps its top bits clear so base plus 63 never wraps
    initial
    begin
        base_rnd   = $random(seed);
        base_addr  = {2'b00, base_rnd[29:0]};
        reset_n    = 1'b0;
        newest_idx = '0;
        rd_grant   = 1'b0;
        rsp_valid  = 1'b0;
        rsp_tag    = '0;
        rsp_data   = '0;
        rx_enable  = 1'b0;
    end

    // ============================================================
    // Producer, host memory and client, one step per rising edge
    // ============================================================
    always @(posedge clk)
    begin
        cyc = cyc + 1;
        if (cyc == 4)
        begin
            reset_n <= 1'b1;
        end

        // Registers are reset from the first edge on
        if (cyc >= 2 && cyc <= 5)
        begin
            check_flag("rd_req", rd_req, 1'b0);
            check_flag("rx_rdy", rx_rdy, 1'b0);
            check_idx("oldest_idx", oldest_idx, '0);
        end

        if (cyc >= 5 && !done)
        begin
            // A request must always have a written line behind it
            if (rd_req && req_cnt == wr_cnt)
                report("rd_req is high although every written line was requested");
            if (rd_grant && !rd_req)
                report("rd_grant was driven while rd_req was low");

            // Lines between request and FIFO fill the scoreboard, and a full
            // scoreboard has to hold the request back
            ahead = ring_idx_t'(req_cnt) - oldest_idx;
            if (rd_req && ahead >= N_SLOTS)
                report("rd_req is high although every scoreboard slot is allocated");

            // Accept a granted request and record it as pending
            if (rd_grant && rd_req)
            begin
                check_addr("rd_addr", rd_addr,
                           base_addr + line_addr_t'(req_cnt % RING_SIZE));
                foreach (pend_tag[i])
                begin
                    if (pend_tag[i] == rd_tag)
                        report("a tag was issued again while still pending");
                end
                pend_addr.push_back(rd_addr);
                pend_tag.push_back(rd_tag);
                req_cnt++;
            end

            // Client pop, lines must come out strictly in ring order
            if (rx_rdy && rx_enable)
            begin
                check_line("rx_data", rx_data, expected_line(pop_cnt));
                pop_cnt++;
            end

            // FIFO holds at most two lines past the popped count
            ahead = oldest_idx - ring_idx_t'(pop_cnt);
            if (ahead > 2)
            begin
                errors++;
                $display("** Error at %0t: oldest_idx = %h, expected %h to %h", $time,
                         oldest_idx, ring_idx_t'(pop_cnt), ring_idx_t'(pop_cnt + 2));
            end

            if (pop_cnt == TOTAL_LINES)
            begin
                check_idx("oldest_idx", oldest_idx, ring_idx_t'(TOTAL_LINES));
                if (pend_tag.size() != 0 || req_cnt != TOTAL_LINES)
                    report("reads are still outstanding after the last line");
                done = 1'b1;
            end

            // Producer stops one short of a full ring
            ahead = ring_idx_t'(wr_cnt) - oldest_idx;
            if (wr_cnt < TOTAL_LINES && ahead < RING_SIZE - 1 && ($random(seed) & 1))
            begin
                host_mem[base_addr + line_addr_t'(wr_cnt % RING_SIZE)] = expected_line(wr_cnt);
                wr_cnt++;
                newest_idx <= ring_idx_t'(wr_cnt);
            end

            // Return one random pending read
            if (pend_tag.size() > 0 && ($random(seed) & 1))
            begin
                k = $unsigned($random(seed)) % pend_tag.size();
                if (!host_mem.exists(pend_addr[k]))
                    report("a read targeted an address that was never written");
                rsp_valid <= 1'b1;
                rsp_tag   <= pend_tag[k];
                rsp_data  <= host_mem[pend_addr[k]];
                pend_addr.delete(k);
                pend_tag.delete(k);
            end
            else
            begin
                rsp_valid <= 1'b0;
            end

            // Grant only when rd_req is certain to be high in the next cycle
            ahead = ring_idx_t'(req_cnt) - oldest_idx;
            rd_grant <= (req_cnt != wr_cnt) && (ahead < N_SLOTS) &&
                        (($random(seed) & 3) != 0);

            // Client stalls once for a long stretch to fill the scoreboard
            if (!bp_done && pop_cnt >= 200)
            begin
                bp_done = 1'b1;
                bp_left = BP_CYCLES;
            end
            if (bp_left > 0)
            begin
                bp_left--;
                rx_enable <= 1'b0;
            end
            else
            begin
                rx_enable <= (($random(seed) & 1) != 0);
            end
        end
    end

    initial
    begin
        wait (done);
        $display("Run finished with %0d errors after %0d lines", errors, pop_cnt);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Run timed out with %0d errors and %0d of %0d lines received",
                 errors, pop_cnt, TOTAL_LINES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
host_chan_pkg.sv
ring_buf_pkg.sv
host_chan_if.sv
out_fifo2.sv
reorder_scoreboard.sv
ring_reader.sv
ring_reader_top.sv
tb_ring_reader.sv
